/* build.f */
+incdir+testbench
src/ps2_pkg.sv
src/apb_pkg.sv
src/ps2_rx.sv
src/scan_decoder.sv
src/event_fifo.sv
src/key_apb_regs.sv
src/keyboard_top.sv
testbench/keyboard_tb.sv

/* src/apb_pkg.sv */
// Host bus types and APB register map, imported by the register block and the top level
package apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Register offsets
    localparam apb_addr_t REG_JOY1      = 8'h00;
    localparam apb_addr_t REG_JOY2      = 8'h04;
    localparam apb_addr_t REG_COINSTART = 8'h08;  // Start 7:4, coin 3:0
    localparam apb_addr_t REG_SYS       = 8'h0C;  // Service, reset, pause in 2:0
    localparam apb_addr_t REG_STATUS    = 8'h10;  // Error count 15:8, empty 1, overflow 0
    localparam apb_addr_t REG_EVENT     = 8'h14;  // Valid 31, event 9:0, pops on read

    // STATUS write bits, write 1 to clear
    localparam int STATUS_CLR_OVF = 0;
    localparam int STATUS_CLR_ERR = 1;

    localparam int EVENT_VALID_BIT = 31;

endpackage

/* src/event_fifo.sv */
// Show-ahead key-event FIFO between the decoder and the host registers, with sticky overflow
`timescale 1ns/1ps

module event_fifo
    import ps2_pkg::*;
#(
    parameter int FIFO_DEPTH = 8  // Power of two
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push_i,
    input  key_event_t data_i,
    input  logic       pop_i,
    input  logic       clr_overflow_i,
    output key_event_t data_o,
    output logic       empty_o,
    output logic       overflow_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    key_event_t    mem [FIFO_DEPTH];
    logic [AW:0]   wr_ptr;  // Extra bit tells full from empty
    logic [AW:0]   rd_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_push = push_i & ~full;  // Dropped when full
    assign do_pop  = pop_i & ~empty_o;
    assign data_o  = mem[rd_ptr[AW-1:0]];  // Head visible while not empty

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr[AW-1:0]] <= data_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // New loss beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst)
            overflow_o <= 1'b0;
        else if (push_i && full)
            overflow_o <= 1'b1;
        else if (clr_overflow_i)
            overflow_o <= 1'b0;
    end

    // Register block only pops what it has seen
    assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_o);

endmodule

/* src/key_apb_regs.sv */
// APB slave through which the host reads key state and status, pops the event queue and clears flags
`timescale 1ns/1ps

module key_apb_regs
    import ps2_pkg::*;
    import apb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    input  joy_t       joy1_i,
    input  joy_t       joy2_i,
    input  nibble_t    coin_i,
    input  nibble_t    start_i,
    input  logic       pause_i,
    input  logic       reset_key_i,
    input  logic       service_i,
    input  key_event_t fifo_data_i,
    input  logic       fifo_empty_i,
    input  logic       overflow_i,
    input  logic [7:0] frame_err_cnt_i,
    output apb_data_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,
    output logic       pop_o,
    output logic       clr_overflow_o,
    output logic       clr_err_cnt_o
);

    logic      setup;
    logic      access;
    logic      mapped;
    logic      evt_pend_q;  // Setup saw a valid head to pop in access
    apb_data_t rd_mux;

    assign setup  = psel_i & ~penable_i;
    assign access = psel_i & penable_i;

    always_comb begin
        mapped = 1'b1;
        rd_mux = '0;
        case (paddr_i)
            REG_JOY1:      rd_mux = {22'd0, joy1_i};
            REG_JOY2:      rd_mux = {22'd0, joy2_i};
            REG_COINSTART: rd_mux = {24'd0, start_i, coin_i};
            REG_SYS:       rd_mux = {29'd0, service_i, reset_key_i, pause_i};
            REG_STATUS:    rd_mux = {16'd0, frame_err_cnt_i, 6'd0, fifo_empty_i, overflow_i};
            REG_EVENT: begin
                if (!fifo_empty_i) begin
                    rd_mux                  = {22'd0, fifo_data_i};
                    rd_mux[EVENT_VALID_BIT] = 1'b1;
                end
            end
            default:       mapped = 1'b0;
        endcase
    end

    // Snapshot taken in setup and held through the access phase
    always_ff @(posedge clk) begin
        if (setup)
            prdata_o <= rd_mux;
    end

    always_ff @(posedge clk) begin
        if (rst)
            evt_pend_q <= 1'b0;
        else if (setup)
            evt_pend_q <= !pwrite_i && paddr_i == REG_EVENT && !fifo_empty_i;
        else
            evt_pend_q <= 1'b0;
    end

    assign pready_o       = 1'b1;  // No wait states
    assign pslverr_o      = access & (~mapped | (pwrite_i & paddr_i != REG_STATUS));
    assign pop_o          = access & evt_pend_q;
    assign clr_overflow_o = access & pwrite_i & (paddr_i == REG_STATUS) & pwdata_i[STATUS_CLR_OVF];
    assign clr_err_cnt_o  = access & pwrite_i & (paddr_i == REG_STATUS) & pwdata_i[STATUS_CLR_ERR];

    // Pop only in the access phase of an EVENT read
    assert property (@(posedge clk) disable iff (rst)
        pop_o |-> access && !pwrite_i && paddr_i == REG_EVENT);

endmodule

/* src/keyboard_top.sv */
// Keyboard controller top level, PS/2 in, APB to the host, sets FIFO depth and receive timeout
`timescale 1ns/1ps

module keyboard_top
    import ps2_pkg::*;
    import apb_pkg::*;
#(
    parameter int FIFO_DEPTH = 8,
    parameter int RX_TIMEOUT = 2000
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      ps2_clk_i,
    input  logic      ps2_data_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    scan_byte_t rx_byte;
    logic       rx_valid, rx_err;
    joy_t       joy1, joy2;
    nibble_t    coin, start;
    logic       pause, reset_key, service;
    key_event_t evt, fifo_head;
    logic       push, pop, fifo_empty, overflow;
    logic       clr_ovf, clr_err;
    logic [7:0] err_cnt;

    // Producer
    ps2_rx #(.RX_TIMEOUT(RX_TIMEOUT)) u_rx (
        .clk, .rst, .ps2_clk_i, .ps2_data_i,
        .byte_o(rx_byte), .byte_valid_o(rx_valid), .frame_err_o(rx_err)
    );

    scan_decoder u_dec (
        .clk, .rst, .byte_i(rx_byte), .byte_valid_i(rx_valid), .frame_err_i(rx_err),
        .clr_err_cnt_i(clr_err), .joy1_o(joy1), .joy2_o(joy2), .coin_o(coin),
        .start_o(start), .pause_o(pause), .reset_key_o(reset_key), .service_o(service),
        .event_o(evt), .push_o(push), .frame_err_cnt_o(err_cnt)
    );

    // Buffer
    event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk, .rst, .push_i(push), .data_i(evt), .pop_i(pop), .clr_overflow_i(clr_ovf),
        .data_o(fifo_head), .empty_o(fifo_empty), .overflow_o(overflow)
    );

    // Consumer
    key_apb_regs u_regs (
        .clk, .rst, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .joy1_i(joy1), .joy2_i(joy2), .coin_i(coin), .start_i(start), .pause_i(pause),
        .reset_key_i(reset_key), .service_i(service), .fifo_data_i(fifo_head),
        .fifo_empty_i(fifo_empty), .overflow_i(overflow), .frame_err_cnt_i(err_cnt),
        .prdata_o, .pready_o, .pslverr_o, .pop_o(pop), .clr_overflow_o(clr_ovf),
        .clr_err_cnt_o(clr_err)
    );

endmodule

/* src/ps2_pkg.sv */
// Keyboard-side types and PS/2 scan-code constants, imported by the receiver, decoder and FIFO
package ps2_pkg;

    typedef logic [7:0] scan_byte_t;  // One received PS/2 byte
    typedef logic [9:0] key_event_t;  // {release, extended, scan code}
    typedef logic [9:0] joy_t;        // Buttons 6..1 in 9:4, up/down/left/right in 3:0
    typedef logic [3:0] nibble_t;     // Coin and start vectors

    // Prefix bytes
    localparam scan_byte_t SC_EXTEND  = 8'hE0;
    localparam scan_byte_t SC_RELEASE = 8'hF0;

    // Arrow keys, only valid after E0
    localparam scan_byte_t SC_UP    = 8'h75;
    localparam scan_byte_t SC_DOWN  = 8'h72;
    localparam scan_byte_t SC_LEFT  = 8'h6B;
    localparam scan_byte_t SC_RIGHT = 8'h74;

    // Joystick 1 buttons
    localparam scan_byte_t SC_A = 8'h1C;
    localparam scan_byte_t SC_S = 8'h1B;
    localparam scan_byte_t SC_D = 8'h23;
    localparam scan_byte_t SC_Z = 8'h1A;
    localparam scan_byte_t SC_X = 8'h22;
    localparam scan_byte_t SC_C = 8'h21;

    // Joystick 2
    localparam scan_byte_t SC_J = 8'h3B;  // Left
    localparam scan_byte_t SC_K = 8'h42;  // Down
    localparam scan_byte_t SC_I = 8'h43;  // Up
    localparam scan_byte_t SC_L = 8'h4B;  // Right
    localparam scan_byte_t SC_Q = 8'h15;  // Button 1
    localparam scan_byte_t SC_W = 8'h1D;  // Button 2

    // Coins on 5..8, starts on 1..4
    localparam scan_byte_t SC_5 = 8'h2E;
    localparam scan_byte_t SC_6 = 8'h36;
    localparam scan_byte_t SC_7 = 8'h3D;
    localparam scan_byte_t SC_8 = 8'h3E;
    localparam scan_byte_t SC_1 = 8'h16;
    localparam scan_byte_t SC_2 = 8'h1E;
    localparam scan_byte_t SC_3 = 8'h26;
    localparam scan_byte_t SC_4 = 8'h25;

    // System keys
    localparam scan_byte_t SC_P  = 8'h4D;  // Pause
    localparam scan_byte_t SC_F3 = 8'h04;  // Reset
    localparam scan_byte_t SC_9  = 8'h46;  // Service

endpackage

/* src/ps2_rx.sv */
// PS/2 receiver, synchronizes the keyboard lines and delivers checked bytes as one-cycle strobes
`timescale 1ns/1ps

module ps2_rx
    import ps2_pkg::*;
#(
    parameter int RX_TIMEOUT = 2000  // Idle clk cycles before a partial frame is dropped
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk_i,
    input  logic       ps2_data_i,
    output scan_byte_t byte_o,
    output logic       byte_valid_o,
    output logic       frame_err_o
);

    localparam int TW = $clog2(RX_TIMEOUT);

    typedef enum logic [1:0] {IDLE, SHIFT, CHECK} rx_state_t;

    rx_state_t   state;
    logic [2:0]  clk_sync;   // Two sync flops plus edge history
    logic [1:0]  data_sync;
    logic        ps2_fall;
    logic [10:0] frame_q;    // Stop, parity, data 7..0, start
    logic [3:0]  bit_cnt;
    logic [TW-1:0] wdog;
    logic        frame_ok;

    assign ps2_fall = clk_sync[2] & ~clk_sync[1];
    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame_q[0] & frame_q[10] & (^frame_q[9:1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 3'b111;  // Lines idle high
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk_i};
            data_sync <= {data_sync[0], ps2_data_i};
        end
    end

    // Data arrives LSB first, shifted in from the top
    always_ff @(posedge clk) begin
        if (ps2_fall)
            frame_q <= {data_sync[1], frame_q[10:1]};
        if (state == CHECK)
            byte_o <= frame_q[8:1];
    end

    always_ff @(posedge clk) begin
        byte_valid_o <= 1'b0;
        frame_err_o  <= 1'b0;
        if (rst) begin
            state   <= IDLE;
            bit_cnt <= '0;
            wdog    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    wdog <= '0;
                    if (ps2_fall) begin  // Start bit
                        bit_cnt <= 4'd1;
                        state   <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (ps2_fall) begin
                        wdog    <= '0;
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd10)  // Stop bit just sampled
                            state <= CHECK;
                    end else if (wdog == TW'(RX_TIMEOUT - 1)) begin
                        state <= IDLE;  // Keyboard went quiet, drop silently
                    end else begin
                        wdog <= wdog + 1'b1;
                    end
                end
                CHECK: begin
                    byte_valid_o <= frame_ok;
                    frame_err_o  <= ~frame_ok;
                    state        <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Decoder sees either a byte or an error per frame, never both
    assert property (@(posedge clk) disable iff (rst) !(byte_valid_o && frame_err_o));

endmodule

/* src/scan_decoder.sv */
// Scan-code decoder, tracks E0/F0 prefixes, keeps the key-state vectors and emits key events
`timescale 1ns/1ps

module scan_decoder
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  scan_byte_t byte_i,
    input  logic       byte_valid_i,
    input  logic       frame_err_i,
    input  logic       clr_err_cnt_i,
    output joy_t       joy1_o,
    output joy_t       joy2_o,
    output nibble_t    coin_o,
    output nibble_t    start_o,
    output logic       pause_o,
    output logic       reset_key_o,
    output logic       service_o,
    output key_event_t event_o,
    output logic       push_o,
    output logic [7:0] frame_err_cnt_o
);

    logic ext_q;  // E0 seen
    logic rel_q;  // F0 seen
    logic make;

    assign make = ~rel_q;  // Break clears the bit

    always_ff @(posedge clk) begin
        push_o <= 1'b0;
        if (rst) begin
            ext_q       <= 1'b0;
            rel_q       <= 1'b0;
            joy1_o      <= '0;
            joy2_o      <= '0;
            coin_o      <= '0;
            start_o     <= '0;
            pause_o     <= 1'b0;
            reset_key_o <= 1'b0;
            service_o   <= 1'b0;
        end else if (byte_valid_i) begin
            if (byte_i == SC_EXTEND) begin
                ext_q <= 1'b1;
            end else if (byte_i == SC_RELEASE) begin
                rel_q <= 1'b1;
            end else begin
                ext_q  <= 1'b0;  // Sequence complete
                rel_q  <= 1'b0;
                push_o <= 1'b1;  // Every code is queued, mapped or not
                case ({ext_q, byte_i})
                    // Joystick 1
                    {1'b1, SC_RIGHT}: joy1_o[0] <= make;
                    {1'b1, SC_LEFT}:  joy1_o[1] <= make;
                    {1'b1, SC_DOWN}:  joy1_o[2] <= make;
                    {1'b1, SC_UP}:    joy1_o[3] <= make;
                    {1'b0, SC_A}:     joy1_o[4] <= make;
                    {1'b0, SC_S}:     joy1_o[5] <= make;
                    {1'b0, SC_D}:     joy1_o[6] <= make;
                    {1'b0, SC_Z}:     joy1_o[7] <= make;
                    {1'b0, SC_X}:     joy1_o[8] <= make;
                    {1'b0, SC_C}:     joy1_o[9] <= make;
                    // Joystick 2, buttons 3..6 unmapped
                    {1'b0, SC_L}:     joy2_o[0] <= make;
                    {1'b0, SC_J}:     joy2_o[1] <= make;
                    {1'b0, SC_K}:     joy2_o[2] <= make;
                    {1'b0, SC_I}:     joy2_o[3] <= make;
                    {1'b0, SC_Q}:     joy2_o[4] <= make;
                    {1'b0, SC_W}:     joy2_o[5] <= make;
                    // Coins
                    {1'b0, SC_5}:     coin_o[0] <= make;
                    {1'b0, SC_6}:     coin_o[1] <= make;
                    {1'b0, SC_7}:     coin_o[2] <= make;
                    {1'b0, SC_8}:     coin_o[3] <= make;
                    // Starts
                    {1'b0, SC_1}:     start_o[0] <= make;
                    {1'b0, SC_2}:     start_o[1] <= make;
                    {1'b0, SC_3}:     start_o[2] <= make;
                    {1'b0, SC_4}:     start_o[3] <= make;
                    // System
                    {1'b0, SC_P}:     pause_o     <= make;
                    {1'b0, SC_F3}:    reset_key_o <= make;
                    {1'b0, SC_9}:     service_o   <= make;
                    default: ;  // Queued only
                endcase
            end
        end
    end

    // Event payload, qualified by push_o
    always_ff @(posedge clk) begin
        if (byte_valid_i)
            event_o <= {rel_q, ext_q, byte_i};
    end

    // Frame error count, saturates, host clear wins
    always_ff @(posedge clk) begin
        if (rst || clr_err_cnt_i)
            frame_err_cnt_o <= '0;
        else if (frame_err_i && frame_err_cnt_o != 8'hFF)
            frame_err_cnt_o <= frame_err_cnt_o + 8'd1;
    end

endmodule

/* testbench/keyboard_tb_tasks.svh */
// Keyboard testbench tasks, included inside the testbench module for PS/2, APB and the tests
`ifndef KEYBOARD_TB_TASKS_SVH
`define KEYBOARD_TB_TASKS_SVH

task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first failure");
endtask

task automatic check_joy(input string name, input joy_t exp, input joy_t act);
    if (act !== exp) begin
        $display("Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
        fail_run();
    end
endtask

task automatic check_nibble(input string name, input nibble_t exp, input nibble_t act);
    if (act !== exp) begin
        $display("Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
        fail_run();
    end
endtask

task automatic check_event(input string name, input key_event_t exp, input key_event_t act);
    if (act !== exp) begin
        $display("Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
        fail_run();
    end
endtask

task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
    if (act !== exp) begin
        $display("Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
        fail_run();
    end
endtask

// One 11-bit frame, start, data LSB first, odd parity, stop
task automatic send_frame(input scan_byte_t code, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
        @(negedge clk);
        ps2_data = bits[i];  // Data changes while ps2 clock is high
        repeat (PS2_HALF) @(negedge clk);
        ps2_clk = 1'b0;
        repeat (PS2_HALF) @(negedge clk);
        ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
endtask

task automatic send_key(input scan_byte_t code, input logic ext, input logic rel);
    if (ext)
        send_frame(8'hE0, 1'b0);
    if (rel)
        send_frame(8'hF0, 1'b0);
    send_frame(code, 1'b0);
endtask

task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;  // Access phase
    @(posedge clk);
    data = prdata;
    err  = pslverr;
    check_data("pready_o", 32'd1, {31'd0, pready});
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    err = pslverr;
    check_data("pready_o", 32'd1, {31'd0, pready});
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

// Reads until the masked register equals value
task automatic poll_until(input apb_addr_t addr, input apb_data_t mask, input apb_data_t value);
    apb_data_t d;
    logic      e;
    int        tries;
    tries = 0;
    apb_read(addr, d, e);
    while ((d & mask) !== value) begin
        tries++;
        if (tries > POLL_LIMIT) begin
            $display("Timeout: register 0x%h never reached 0x%h under mask 0x%h",
                     addr, value, mask);
            fail_run();
        end
        apb_read(addr, d, e);
    end
endtask

task automatic expect_event(input key_event_t exp);
    apb_data_t d;
    logic      e;
    apb_read(REG_EVENT, d, e);
    check_data("REG_EVENT[31:10]", 32'h8000_0000, d & 32'hFFFF_FC00);  // Valid, rest zero
    check_event("REG_EVENT[9:0]", exp, d[9:0]);
endtask

// Send a key, wait until it is queued, then pop and check its event
task automatic key_stroke(input scan_byte_t code, input logic ext, input logic rel);
    send_key(code, ext, rel);
    poll_until(REG_STATUS, 32'h2, 32'h0);  // Empty bit drops
    expect_event({rel, ext, code});
endtask

task automatic joy1_button_press();
    int        idx;
    joy_t      exp;
    apb_data_t d;
    logic      e;
    idx = $urandom % 6;
    exp = '0;
    exp[4 + idx] = 1'b1;
    key_stroke(JOY1_BTN[idx*8 +: 8], 1'b0, 1'b0);
    apb_read(REG_JOY1, d, e);
    check_joy("REG_JOY1", exp, d[9:0]);
    key_stroke(JOY1_BTN[idx*8 +: 8], 1'b0, 1'b1);
    apb_read(REG_JOY1, d, e);
    check_joy("REG_JOY1", '0, d[9:0]);
endtask

task automatic arrow_keys();
    int        idx;
    joy_t      exp;
    apb_data_t d;
    logic      e;
    idx = $urandom % 4;
    exp = '0;
    exp[idx] = 1'b1;
    key_stroke(ARROWS[idx*8 +: 8], 1'b1, 1'b0);
    apb_read(REG_JOY1, d, e);
    check_joy("REG_JOY1", exp, d[9:0]);
    key_stroke(ARROWS[idx*8 +: 8], 1'b1, 1'b1);
    apb_read(REG_JOY1, d, e);
    check_joy("REG_JOY1", '0, d[9:0]);
    key_stroke(8'h75, 1'b0, 1'b0);  // Up code without E0 is unmapped
    apb_read(REG_JOY1, d, e);
    check_joy("REG_JOY1", '0, d[9:0]);
endtask

task automatic coin_and_start();
    int        c;
    int        s;
    apb_data_t d;
    logic      e;
    c = $urandom % 4;
    s = $urandom % 4;
    key_stroke(COIN_KEY[c*8 +: 8], 1'b0, 1'b0);
    key_stroke(STRT_KEY[s*8 +: 8], 1'b0, 1'b0);
    apb_read(REG_COINSTART, d, e);
    check_nibble("REG_COINSTART[3:0]", 4'd1 << c, d[3:0]);
    check_nibble("REG_COINSTART[7:4]", 4'd1 << s, d[7:4]);
    key_stroke(COIN_KEY[c*8 +: 8], 1'b0, 1'b1);
    key_stroke(STRT_KEY[s*8 +: 8], 1'b0, 1'b1);
    apb_read(REG_COINSTART, d, e);
    check_nibble("REG_COINSTART[3:0]", 4'd0, d[3:0]);
    check_nibble("REG_COINSTART[7:4]", 4'd0, d[7:4]);
endtask

task automatic joy2_keys();
    int        idx;
    apb_data_t d;
    logic      e;
    idx = $urandom % 6;
    key_stroke(JOY2_KEY[idx*8 +: 8], 1'b0, 1'b0);
    apb_read(REG_JOY2, d, e);
    check_joy("REG_JOY2", 10'd1 << idx, d[9:0]);
    key_stroke(JOY2_KEY[idx*8 +: 8], 1'b0, 1'b1);
    apb_read(REG_JOY2, d, e);
    check_joy("REG_JOY2", '0, d[9:0]);
endtask

task automatic system_keys();
    apb_data_t d;
    logic      e;
    for (int k = 0; k < 3; k++) begin
        key_stroke(SYS_KEYS[k*8 +: 8], 1'b0, 1'b0);
        apb_read(REG_SYS, d, e);
        check_data("REG_SYS", 32'd1 << k, d);
        key_stroke(SYS_KEYS[k*8 +: 8], 1'b0, 1'b1);
        apb_read(REG_SYS, d, e);
        check_data("REG_SYS", 32'd0, d);
    end
endtask

task automatic parity_error();
    apb_data_t d;
    logic      e;
    send_frame(8'h1C, 1'b1);  // Button key with flipped parity
    poll_until(REG_STATUS, 32'h0000_FF00, 32'h0000_0100);
    apb_read(REG_STATUS, d, e);
    check_data("REG_STATUS", 32'h0000_0102, d);  // Count 1, still empty
    apb_read(REG_JOY1, d, e);
    check_joy("REG_JOY1", '0, d[9:0]);
    apb_write(REG_STATUS, 32'h2, e);
    apb_read(REG_STATUS, d, e);
    check_data("REG_STATUS", 32'h0000_0002, d);
endtask

// Six keys into a four-deep queue
task automatic queue_overflow();
    apb_data_t d;
    logic      e;
    for (int k = 0; k < 4; k++) begin
        send_key(COIN_KEY[k*8 +: 8], 1'b0, 1'b0);
        poll_until(REG_COINSTART, 32'd1 << k, 32'd1 << k);
    end
    for (int k = 0; k < 2; k++) begin
        send_key(STRT_KEY[k*8 +: 8], 1'b0, 1'b0);
        poll_until(REG_COINSTART, 32'd16 << k, 32'd16 << k);
    end
    apb_read(REG_STATUS, d, e);
    check_data("REG_STATUS", 32'h0000_0001, d);  // Overflow, not empty
    for (int k = 0; k < 4; k++)
        expect_event({2'b00, COIN_KEY[k*8 +: 8]});
    apb_read(REG_EVENT, d, e);
    check_data("REG_EVENT", 32'd0, d);
    apb_read(REG_COINSTART, d, e);
    check_nibble("REG_COINSTART[3:0]", 4'hF, d[3:0]);
    check_nibble("REG_COINSTART[7:4]", 4'h3, d[7:4]);
    apb_write(REG_STATUS, 32'h1, e);
    apb_read(REG_STATUS, d, e);
    check_data("REG_STATUS", 32'h0000_0002, d);
endtask

task automatic bus_errors();
    apb_data_t d;
    logic      e;
    apb_read(8'h18, d, e);  // Past the last register
    check_data("pslverr_o", 32'd1, {31'd0, e});
    apb_write(REG_JOY1, 32'h3FF, e);
    check_data("pslverr_o", 32'd1, {31'd0, e});
    apb_read(REG_JOY1, d, e);
    check_data("pslverr_o", 32'd0, {31'd0, e});
    check_joy("REG_JOY1", '0, d[9:0]);  // Write had no effect
endtask

`endif

/* testbench/keyboard_tb.sv */
// Directed testbench for the PS/2 keyboard controller, sends keystrokes and checks them over APB
`timescale 1ns/1ps

module keyboard_tb
    import ps2_pkg::*;
    import apb_pkg::*;
();

    localparam int PS2_HALF   = 8;    // clk cycles per ps2 clock phase
    localparam int POLL_LIMIT = 100;  // APB reads before a wait gives up

    // Key tables from the key map, index 0 in the low byte
    localparam logic [47:0] JOY1_BTN = {8'h21, 8'h22, 8'h1A, 8'h23, 8'h1B, 8'h1C};  // Bits 4..9
    localparam logic [31:0] ARROWS   = {8'h75, 8'h72, 8'h6B, 8'h74};  // Right, left, down, up
    localparam logic [47:0] JOY2_KEY = {8'h1D, 8'h15, 8'h43, 8'h42, 8'h3B, 8'h4B};  // Bits 0..5
    localparam logic [31:0] COIN_KEY = {8'h3E, 8'h3D, 8'h36, 8'h2E};
    localparam logic [31:0] STRT_KEY = {8'h25, 8'h26, 8'h1E, 8'h16};
    localparam logic [23:0] SYS_KEYS = {8'h46, 8'h04, 8'h4D};  // Pause, reset, service

    logic      clk;
    logic      rst;
    logic      ps2_clk;
    logic      ps2_data;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    int        seed_dummy;

    keyboard_top #(
        .FIFO_DEPTH(4),  // Small queue so overflow is quick to reach
        .RX_TIMEOUT(2000)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk_i  (ps2_clk),
        .ps2_data_i (ps2_data),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .prdata_o   (prdata),
        .pready_o   (pready),
        .pslverr_o  (pslverr)
    );

    always #50 clk = ~clk;  // 100 ns period

    `include "keyboard_tb_tasks.svh"

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        ps2_clk  = 1'b1;  // PS/2 lines idle high
        ps2_data = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        seed_dummy = $urandom(32'h4dae721d);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        joy1_button_press();
        arrow_keys();
        coin_and_start();
        joy2_keys();
        system_keys();
        parity_error();
        queue_overflow();
        bus_errors();

        $display("=== PASS ===");
        $finish;
    end

endmodule
